/* verilog/csr_defs.svh */
// shared widths, CSR numbers and fixed values for the machine-mode CSR block
// include in any RTL or testbench file that needs a width, an address or an ID value

`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// ----------------------------------------
// widths
`define CSR_XLEN          32
`define CSR_ADDR_W        12
`define CSR_CNT_W         64

// ----------------------------------------
// machine trap setup and handling
`define CSR_MSTATUS       12'h300
`define CSR_MISA          12'h301
`define CSR_MIE           12'h304
`define CSR_MTVEC         12'h305
`define CSR_MCOUNTEREN    12'h306
`define CSR_MCOUNTINHIBIT 12'h320
`define CSR_MSCRATCH      12'h340
`define CSR_MEPC          12'h341
`define CSR_MCAUSE        12'h342
`define CSR_MTVAL         12'h343

// machine counters, low half at 0xB0x and high half at 0xB8x
`define CSR_MCYCLE        12'hB00
`define CSR_MCYCLEH       12'hB80
`define CSR_MINSTRET      12'hB02
`define CSR_MINSTRETH     12'hB82

// user counter shadows, read-only space 0xCxx
`define CSR_CYCLE         12'hC00
`define CSR_TIME          12'hC01
`define CSR_INSTRET       12'hC02
`define CSR_CYCLEH        12'hC80
`define CSR_TIMEH         12'hC81
`define CSR_INSTRETH      12'hC82

// machine information registers
`define CSR_MVENDORID     12'hF11
`define CSR_MARCHID       12'hF12
`define CSR_MIMPID        12'hF13
`define CSR_MHARTID       12'hF14

// ----------------------------------------
// fixed read values
// misa: mxl=1 (rv32), extensions i and u
`define MISA_VAL          32'h4010_0100
// mstatus: mpp held at machine mode, all enables clear
`define MSTATUS_VAL       32'h0000_1800
`define MVENDORID_VAL     32'h0000_0000
`define MARCHID_VAL       32'h0000_0000
`define MIMPID_VAL        32'h0000_0001
`define MHARTID_VAL       32'h0000_0000

// direct mode, base at 0x100
`define MTVEC_RESET       32'h0000_0100
// meie (11), mtie (7), msie (3)
`define MIE_MASK          32'h0000_0888

`endif

/* verilog/csr_pkg.sv */
// types shared by the CSR block: privilege mode, register select and the address view
// referenced by scoped name (csr_pkg::...) from the RTL and the testbench

package csr_pkg;

   // only user and machine mode exist in this core
   typedef enum logic [1:0]
   {
      PRIV_U = 2'd0,
      PRIV_M = 2'd3
   } priv_mode_e;

   // one select per kept register, plus the two mtime halves and none
   typedef enum logic [4:0]
   {
      SEL_NONE,
      SEL_MSTATUS,
      SEL_MISA,
      SEL_MIE,
      SEL_MTVEC,
      SEL_MCOUNTEREN,
      SEL_MCOUNTINHIBIT,
      SEL_MSCRATCH,
      SEL_MEPC,
      SEL_MCAUSE,
      SEL_MTVAL,
      SEL_MCYCLE,
      SEL_MCYCLEH,
      SEL_MINSTRET,
      SEL_MINSTRETH,
      SEL_CYCLE,
      SEL_CYCLEH,
      SEL_TIME_LO,
      SEL_TIME_HI,
      SEL_INSTRET,
      SEL_INSTRETH,
      SEL_MVENDORID,
      SEL_MARCHID,
      SEL_MIMPID,
      SEL_MHARTID
   } csr_sel_e;

   // ----------------------------------------
   // the 12-bit CSR number, read two ways
   typedef union packed
   {
      // privilege view: access 3 = read-only
      struct packed
      {
         logic [1:0] access;
         logic [1:0] lowest;
         logic [7:0] index;
      } priv;
      // counter view: 0xC/0xB space, bit 7 selects the high half
      struct packed
      {
         logic [3:0] space;
         logic       high;
         logic [1:0] rsvd;
         logic [4:0] num;
      } cnt;
   } csr_addr_u;

endpackage

/* verilog/csr_decode.sv */
// CSR address decode for the machine-mode CSR block
// combinational: maps a CSR number to a register select and decides whether
// the access is legal for the current privilege mode and access type

`timescale 1ns/1ps

`include "csr_defs.svh"

module csr_decode
(
   input  logic [`CSR_ADDR_W-1:0] adr,
   input  logic                   we,
   input  csr_pkg::priv_mode_e    priv_mode,
   input  logic [`CSR_XLEN-1:0]   mcounteren,
   output csr_pkg::csr_sel_e      sel,
   output logic                   legal
);

   csr_pkg::csr_addr_u csr_adr;
   logic               exists;
   logic               read_only;
   logic               priv_ok;
   logic               user_cnt;
   logic               cnt_ok;

   assign csr_adr = adr;

   // ----------------------------------------
   // address to select
   always_comb
   begin
      sel = csr_pkg::SEL_NONE;
      case (adr)
         `CSR_MSTATUS:       sel = csr_pkg::SEL_MSTATUS;
         `CSR_MISA:          sel = csr_pkg::SEL_MISA;
         `CSR_MIE:           sel = csr_pkg::SEL_MIE;
         `CSR_MTVEC:         sel = csr_pkg::SEL_MTVEC;
         `CSR_MCOUNTEREN:    sel = csr_pkg::SEL_MCOUNTEREN;
         `CSR_MCOUNTINHIBIT: sel = csr_pkg::SEL_MCOUNTINHIBIT;
         `CSR_MSCRATCH:      sel = csr_pkg::SEL_MSCRATCH;
         `CSR_MEPC:          sel = csr_pkg::SEL_MEPC;
         `CSR_MCAUSE:        sel = csr_pkg::SEL_MCAUSE;
         `CSR_MTVAL:         sel = csr_pkg::SEL_MTVAL;
         `CSR_MCYCLE:        sel = csr_pkg::SEL_MCYCLE;
         `CSR_MCYCLEH:       sel = csr_pkg::SEL_MCYCLEH;
         `CSR_MINSTRET:      sel = csr_pkg::SEL_MINSTRET;
         `CSR_MINSTRETH:     sel = csr_pkg::SEL_MINSTRETH;
         `CSR_CYCLE:         sel = csr_pkg::SEL_CYCLE;
         `CSR_CYCLEH:        sel = csr_pkg::SEL_CYCLEH;
         `CSR_TIME:          sel = csr_pkg::SEL_TIME_LO;
         `CSR_TIMEH:         sel = csr_pkg::SEL_TIME_HI;
         `CSR_INSTRET:       sel = csr_pkg::SEL_INSTRET;
         `CSR_INSTRETH:      sel = csr_pkg::SEL_INSTRETH;
         `CSR_MVENDORID:     sel = csr_pkg::SEL_MVENDORID;
         `CSR_MARCHID:       sel = csr_pkg::SEL_MARCHID;
         `CSR_MIMPID:        sel = csr_pkg::SEL_MIMPID;
         `CSR_MHARTID:       sel = csr_pkg::SEL_MHARTID;
         default:            sel = csr_pkg::SEL_NONE;
      endcase
   end

   // ----------------------------------------
   // legality
   assign exists = (sel != csr_pkg::SEL_NONE);

   // access field 3 is read-only by encoding
   // mstatus and misa sit in read-write space but are fixed here
   assign read_only = (csr_adr.priv.access == 2'b11) ||
                      (sel == csr_pkg::SEL_MSTATUS) ||
                      (sel == csr_pkg::SEL_MISA);

   // mode must reach the lowest privilege coded in bits 9:8
   assign priv_ok = (priv_mode >= csr_adr.priv.lowest);

   // user shadows live in 0xC00..0xC9F, bits 6:5 always zero
   assign user_cnt = (csr_adr.cnt.space == 4'hC) && (csr_adr.cnt.rsvd == 2'b00);

   // machine mode reads the shadows freely, user mode needs the mcounteren bit
   assign cnt_ok = !user_cnt || (priv_mode == csr_pkg::PRIV_M) ||
                   mcounteren[csr_adr.cnt.num];

   assign legal = exists && priv_ok && !(we && read_only) && cnt_ok;

endmodule

/* verilog/csr_trap_regs.sv */
// writable machine trap-setup and trap-handling CSRs
// a register is written on the clock edge where wr_en is high and sel names it;
// values feed the read mux, mcounteren goes to decode, mcountinhibit to the counters

`timescale 1ns/1ps

`include "csr_defs.svh"

module csr_trap_regs
(
   input  logic                 clk_in,
   input  logic                 arst_n,
   input  logic                 wr_en,
   input  csr_pkg::csr_sel_e    sel,
   input  logic [`CSR_XLEN-1:0] wr_data,
   output logic [`CSR_XLEN-1:0] mtvec,
   output logic [`CSR_XLEN-1:0] mie,
   output logic [`CSR_XLEN-1:0] mscratch,
   output logic [`CSR_XLEN-1:0] mepc,
   output logic [`CSR_XLEN-1:0] mcause,
   output logic [`CSR_XLEN-1:0] mtval,
   output logic [`CSR_XLEN-1:0] mcounteren,
   output logic [`CSR_XLEN-1:0] mcountinhibit
);

   // mtvec mode field allows only 0 (direct) and 1 (vectored)
   localparam logic [`CSR_XLEN-1:0] MTVEC_WMASK = ~`CSR_XLEN'(2);

   // ----------------------------------------
   // trap registers
   always_ff @(posedge clk_in or negedge arst_n)
   begin
      if (!arst_n)
      begin
         mtvec         <= `MTVEC_RESET;
         mie           <= '0;
         mscratch      <= '0;
         mepc          <= '0;
         mcause        <= '0;
         mtval         <= '0;
         mcounteren    <= '0;
         mcountinhibit <= '0;
      end
      else if (wr_en)
      begin
         case (sel)
            csr_pkg::SEL_MTVEC:
               mtvec <= wr_data & MTVEC_WMASK;
            // only msie, mtie and meie are implemented
            csr_pkg::SEL_MIE:
               mie <= wr_data & `MIE_MASK;
            csr_pkg::SEL_MSCRATCH:
               mscratch <= wr_data;
            csr_pkg::SEL_MEPC:
               mepc <= wr_data;
            csr_pkg::SEL_MCAUSE:
               mcause <= wr_data;
            csr_pkg::SEL_MTVAL:
               mtval <= wr_data;
            // bit n enables user access to counter n
            csr_pkg::SEL_MCOUNTEREN:
               mcounteren <= wr_data;
            // bit 0 stops mcycle, bit 2 stops minstret
            csr_pkg::SEL_MCOUNTINHIBIT:
               mcountinhibit <= wr_data;
            default:
            begin
               // counters and read-only selects are handled elsewhere
            end
         endcase
      end
   end

endmodule

/* verilog/csr_counters.sv */
// 64-bit mcycle and minstret counters
// mcycle counts clocks, minstret counts retire pulses; each is stopped by its
// mcountinhibit bit, and a write to either half takes priority over the count

`timescale 1ns/1ps

`include "csr_defs.svh"

module csr_counters
(
   input  logic                  clk_in,
   input  logic                  arst_n,
   input  logic                  wr_en,
   input  csr_pkg::csr_sel_e     sel,
   input  logic [`CSR_XLEN-1:0]  wr_data,
   input  logic [`CSR_XLEN-1:0]  mcountinhibit,
   input  logic                  retire,
   output logic [`CSR_CNT_W-1:0] mcycle,
   output logic [`CSR_CNT_W-1:0] minstret
);

   logic cyc_inc;
   logic ir_inc;

   // next value of one counter, a half write replaces the increment
   function automatic logic [`CSR_CNT_W-1:0] next_count
   (
      input logic [`CSR_CNT_W-1:0] cur,
      input logic                  inc,
      input logic                  wr_lo,
      input logic                  wr_hi,
      input logic [`CSR_XLEN-1:0]  data
   );
      logic [`CSR_CNT_W-1:0] nxt;
      nxt = cur + {{(`CSR_CNT_W-1){1'b0}}, inc};
      if (wr_lo)
         nxt = {cur[`CSR_CNT_W-1:`CSR_XLEN], data};
      else if (wr_hi)
         nxt = {data, cur[`CSR_XLEN-1:0]};
      return nxt;
   endfunction

   // ----------------------------------------
   assign cyc_inc = !mcountinhibit[0];
   assign ir_inc  = retire && !mcountinhibit[2];

   always_ff @(posedge clk_in or negedge arst_n)
   begin
      if (!arst_n)
      begin
         mcycle   <= '0;
         minstret <= '0;
      end
      else
      begin
         mcycle   <= next_count(mcycle, cyc_inc,
                                wr_en && (sel == csr_pkg::SEL_MCYCLE),
                                wr_en && (sel == csr_pkg::SEL_MCYCLEH), wr_data);
         minstret <= next_count(minstret, ir_inc,
                                wr_en && (sel == csr_pkg::SEL_MINSTRET),
                                wr_en && (sel == csr_pkg::SEL_MINSTRETH), wr_data);
      end
   end

endmodule

/* verilog/csr_wb_response.sv */
// Wishbone classic slave side of the CSR block
// detects a new request, pulses wr_en for a legal write in the request cycle,
// picks the read word by sel and registers it with a one-cycle ack or err

`timescale 1ns/1ps

`include "csr_defs.svh"

module csr_wb_response
(
   input  logic                  clk_in,
   input  logic                  arst_n,
   input  logic                  wb_cyc,
   input  logic                  wb_stb,
   input  logic                  wb_we,
   input  logic                  legal,
   input  csr_pkg::csr_sel_e     sel,
   input  logic [`CSR_XLEN-1:0]  mtvec,
   input  logic [`CSR_XLEN-1:0]  mie,
   input  logic [`CSR_XLEN-1:0]  mscratch,
   input  logic [`CSR_XLEN-1:0]  mepc,
   input  logic [`CSR_XLEN-1:0]  mcause,
   input  logic [`CSR_XLEN-1:0]  mtval,
   input  logic [`CSR_XLEN-1:0]  mcounteren,
   input  logic [`CSR_XLEN-1:0]  mcountinhibit,
   input  logic [`CSR_CNT_W-1:0] mcycle,
   input  logic [`CSR_CNT_W-1:0] minstret,
   input  logic [`CSR_CNT_W-1:0] mtime,
   output logic                  wr_en,
   output logic [`CSR_XLEN-1:0]  wb_dat_r,
   output logic                  wb_ack,
   output logic                  wb_err
);

   logic                 req;
   logic [`CSR_XLEN-1:0] rd_word;

   // ----------------------------------------
   // request detect
   // the master holds stb until it sees a response, so a cycle with ack or
   // err already high is the tail of the previous request
   assign req = wb_cyc && wb_stb && !wb_ack && !wb_err;

   // write lands on the same edge that raises ack
   assign wr_en = req && wb_we && legal;

   // ----------------------------------------
   // read mux
   always_comb
   begin
      case (sel)
         csr_pkg::SEL_MSTATUS:       rd_word = `MSTATUS_VAL;
         csr_pkg::SEL_MISA:          rd_word = `MISA_VAL;
         csr_pkg::SEL_MIE:           rd_word = mie;
         csr_pkg::SEL_MTVEC:         rd_word = mtvec;
         csr_pkg::SEL_MCOUNTEREN:    rd_word = mcounteren;
         csr_pkg::SEL_MCOUNTINHIBIT: rd_word = mcountinhibit;
         csr_pkg::SEL_MSCRATCH:      rd_word = mscratch;
         csr_pkg::SEL_MEPC:          rd_word = mepc;
         csr_pkg::SEL_MCAUSE:        rd_word = mcause;
         csr_pkg::SEL_MTVAL:         rd_word = mtval;
         // machine counters and their user shadows share the same state
         csr_pkg::SEL_MCYCLE,
         csr_pkg::SEL_CYCLE:         rd_word = mcycle[`CSR_XLEN-1:0];
         csr_pkg::SEL_MCYCLEH,
         csr_pkg::SEL_CYCLEH:        rd_word = mcycle[`CSR_CNT_W-1:`CSR_XLEN];
         csr_pkg::SEL_MINSTRET,
         csr_pkg::SEL_INSTRET:       rd_word = minstret[`CSR_XLEN-1:0];
         csr_pkg::SEL_MINSTRETH,
         csr_pkg::SEL_INSTRETH:      rd_word = minstret[`CSR_CNT_W-1:`CSR_XLEN];
         // time comes straight from the platform mtime
         csr_pkg::SEL_TIME_LO:       rd_word = mtime[`CSR_XLEN-1:0];
         csr_pkg::SEL_TIME_HI:       rd_word = mtime[`CSR_CNT_W-1:`CSR_XLEN];
         csr_pkg::SEL_MVENDORID:     rd_word = `MVENDORID_VAL;
         csr_pkg::SEL_MARCHID:       rd_word = `MARCHID_VAL;
         csr_pkg::SEL_MIMPID:        rd_word = `MIMPID_VAL;
         csr_pkg::SEL_MHARTID:       rd_word = `MHARTID_VAL;
         default:                    rd_word = '0;
      endcase
   end

   // ----------------------------------------
   // registered response, one clock after the request edge
   always_ff @(posedge clk_in or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wb_ack   <= 1'b0;
         wb_err   <= 1'b0;
         wb_dat_r <= '0;
      end
      else
      begin
         wb_ack <= req && legal;
         wb_err <= req && !legal;
         // a write returns the old value, like csrrw
         if (req)
            wb_dat_r <= legal ? rd_word : '0;
      end
   end

endmodule

/* verilog/csr_unit.sv */
// top level of the machine-mode CSR block
// Wishbone classic slave addressed by the 12-bit CSR number; an illegal or
// missing CSR answers with err, everything else with ack one clock later

`timescale 1ns/1ps

`include "csr_defs.svh"

module csr_unit
(
   input  logic                  clk_in,
   input  logic                  arst_n,
   // Wishbone classic slave
   input  logic                  wb_cyc,
   input  logic                  wb_stb,
   input  logic                  wb_we,
   input  logic [`CSR_ADDR_W-1:0] wb_adr,
   input  logic [`CSR_XLEN-1:0]  wb_dat_w,
   output logic [`CSR_XLEN-1:0]  wb_dat_r,
   output logic                  wb_ack,
   output logic                  wb_err,
   // core side
   input  csr_pkg::priv_mode_e   priv_mode,
   input  logic                  retire,
   input  logic [`CSR_CNT_W-1:0] mtime
);

   csr_pkg::csr_sel_e     sel;
   logic                  legal;
   logic                  wr_en;
   logic [`CSR_XLEN-1:0]  mtvec;
   logic [`CSR_XLEN-1:0]  mie;
   logic [`CSR_XLEN-1:0]  mscratch;
   logic [`CSR_XLEN-1:0]  mepc;
   logic [`CSR_XLEN-1:0]  mcause;
   logic [`CSR_XLEN-1:0]  mtval;
   logic [`CSR_XLEN-1:0]  mcounteren;
   logic [`CSR_XLEN-1:0]  mcountinhibit;
   logic [`CSR_CNT_W-1:0] mcycle;
   logic [`CSR_CNT_W-1:0] minstret;

   // ----------------------------------------
   // decode
   csr_decode u_decode
   (
      .adr        (wb_adr),
      .we         (wb_we),
      .priv_mode  (priv_mode),
      .mcounteren (mcounteren),
      .sel        (sel),
      .legal      (legal)
   );

   // ----------------------------------------
   // execute: register and counter state
   csr_trap_regs u_trap_regs
   (
      .clk_in        (clk_in),
      .arst_n        (arst_n),
      .wr_en         (wr_en),
      .sel           (sel),
      .wr_data       (wb_dat_w),
      .mtvec         (mtvec),
      .mie           (mie),
      .mscratch      (mscratch),
      .mepc          (mepc),
      .mcause        (mcause),
      .mtval         (mtval),
      .mcounteren    (mcounteren),
      .mcountinhibit (mcountinhibit)
   );

   csr_counters u_counters
   (
      .clk_in        (clk_in),
      .arst_n        (arst_n),
      .wr_en         (wr_en),
      .sel           (sel),
      .wr_data       (wb_dat_w),
      .mcountinhibit (mcountinhibit),
      .retire        (retire),
      .mcycle        (mcycle),
      .minstret      (minstret)
   );

   // ----------------------------------------
   // result: bus response
   csr_wb_response u_wb_response
   (
      .clk_in        (clk_in),
      .arst_n        (arst_n),
      .wb_cyc        (wb_cyc),
      .wb_stb        (wb_stb),
      .wb_we         (wb_we),
      .legal         (legal),
      .sel           (sel),
      .mtvec         (mtvec),
      .mie           (mie),
      .mscratch      (mscratch),
      .mepc          (mepc),
      .mcause        (mcause),
      .mtval         (mtval),
      .mcounteren    (mcounteren),
      .mcountinhibit (mcountinhibit),
      .mcycle        (mcycle),
      .minstret      (minstret),
      .mtime         (mtime),
      .wr_en         (wr_en),
      .wb_dat_r      (wb_dat_r),
      .wb_ack        (wb_ack),
      .wb_err        (wb_err)
   );

endmodule

/* test/csr_unit_assertions.sv */
// concurrent checks on the Wishbone handshake of the CSR block
// bound into csr_unit by the testbench

`timescale 1ns/1ps

module csr_unit_assertions
(
   input logic clk_in,
   input logic arst_n,
   input logic wb_cyc,
   input logic wb_stb,
   input logic wb_ack,
   input logic wb_err
);

   logic req;

   // new request: strobe held with no response on the bus
   assign req = wb_cyc && wb_stb && !wb_ack && !wb_err;

   // ----------------------------------------
   // ack and err never together
   ack_err_exclusive: assert property (@(posedge clk_in) disable iff (!arst_n)
      !(wb_ack && wb_err))
      else $error("wb_ack and wb_err are high in the same cycle");

   // each response is a single-cycle pulse
   ack_one_cycle: assert property (@(posedge clk_in) disable iff (!arst_n)
      wb_ack |=> !wb_ack)
      else $error("wb_ack stayed high for more than one cycle");

   err_one_cycle: assert property (@(posedge clk_in) disable iff (!arst_n)
      wb_err |=> !wb_err)
      else $error("wb_err stayed high for more than one cycle");

   // fixed latency of one clock
   resp_latency: assert property (@(posedge clk_in) disable iff (!arst_n)
      req |=> (wb_ack || wb_err))
      else $error("no response one cycle after a request");

endmodule

/* test/csr_unit_tb.sv */
// testbench for the machine-mode CSR block
// applies a table of Wishbone CSR accesses in user and machine mode,
// then directed counter checks; stops at the first mismatch

`timescale 1ns/1ps

`include "csr_defs.svh"

module csr_unit_tb;

   localparam int CLK_PERIOD    = 20;
   localparam int RESET_CYCLES  = 16;
   localparam int RESP_TIMEOUT  = 8;
   // clocks the watchdog allows per bus access
   localparam int ACCESS_BUDGET = 8;
   localparam int DIRECTED_OPS  = 12;
   localparam int MAX_RETIRE    = 8;

   logic                  clk_in;
   logic                  arst_n;
   logic                  wb_cyc;
   logic                  wb_stb;
   logic                  wb_we;
   logic [`CSR_ADDR_W-1:0] wb_adr;
   logic [`CSR_XLEN-1:0]  wb_dat_w;
   logic [`CSR_XLEN-1:0]  wb_dat_r;
   logic                  wb_ack;
   logic                  wb_err;
   csr_pkg::priv_mode_e   priv_mode;
   logic                  retire;
   logic [`CSR_CNT_W-1:0] mtime;

   // stimulus table, one entry per bus access
   csr_pkg::priv_mode_e   tbl_mode[$];
   logic                  tbl_we[$];
   logic [`CSR_ADDR_W-1:0] tbl_adr[$];
   logic [`CSR_XLEN-1:0]  tbl_wdata[$];
   logic [`CSR_XLEN-1:0]  tbl_exp[$];
   logic                  tbl_err[$];

   logic [`CSR_XLEN-1:0]  rnd [0:11];
   logic [`CSR_CNT_W-1:0] mtime_val;
   longint                watchdog_ns = 0;

   csr_unit UUT
   (
      .clk_in    (clk_in),
      .arst_n    (arst_n),
      .wb_cyc    (wb_cyc),
      .wb_stb    (wb_stb),
      .wb_we     (wb_we),
      .wb_adr    (wb_adr),
      .wb_dat_w  (wb_dat_w),
      .wb_dat_r  (wb_dat_r),
      .wb_ack    (wb_ack),
      .wb_err    (wb_err),
      .priv_mode (priv_mode),
      .retire    (retire),
      .mtime     (mtime)
   );

   bind csr_unit csr_unit_assertions u_assertions
   (
      .clk_in (clk_in),
      .arst_n (arst_n),
      .wb_cyc (wb_cyc),
      .wb_stb (wb_stb),
      .wb_ack (wb_ack),
      .wb_err (wb_err)
   );

   // ----------------------------------------
   // helpers
   task automatic stop_with_error(input string msg);
      $display("%s", msg);
      $display("Simulation finished: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic add_entry(input csr_pkg::priv_mode_e mode, input logic we,
                            input logic [`CSR_ADDR_W-1:0] adr,
                            input logic [`CSR_XLEN-1:0] wdata,
                            input logic [`CSR_XLEN-1:0] exp, input logic err);
      tbl_mode.push_back(mode);
      tbl_we.push_back(we);
      tbl_adr.push_back(adr);
      tbl_wdata.push_back(wdata);
      tbl_exp.push_back(exp);
      tbl_err.push_back(err);
   endtask

   task automatic add_read(input csr_pkg::priv_mode_e mode,
                           input logic [`CSR_ADDR_W-1:0] adr,
                           input logic [`CSR_XLEN-1:0] exp);
      add_entry(mode, 1'b0, adr, '0, exp, 1'b0);
   endtask

   task automatic add_write(input csr_pkg::priv_mode_e mode,
                            input logic [`CSR_ADDR_W-1:0] adr,
                            input logic [`CSR_XLEN-1:0] wdata);
      add_entry(mode, 1'b1, adr, wdata, '0, 1'b0);
   endtask

   task automatic add_error(input csr_pkg::priv_mode_e mode, input logic we,
                            input logic [`CSR_ADDR_W-1:0] adr,
                            input logic [`CSR_XLEN-1:0] wdata);
      add_entry(mode, we, adr, wdata, '0, 1'b1);
   endtask

   // read-only CSR: value, rejected write, value unchanged
   task automatic add_fixed(input logic [`CSR_ADDR_W-1:0] adr,
                            input logic [`CSR_XLEN-1:0] val);
      add_read(csr_pkg::PRIV_M, adr, val);
      add_error(csr_pkg::PRIV_M, 1'b1, adr, ~val);
      add_read(csr_pkg::PRIV_M, adr, val);
   endtask

   // one Wishbone classic cycle, held until ack or err
   task automatic bus_access(input csr_pkg::priv_mode_e mode, input logic we,
                             input logic [`CSR_ADDR_W-1:0] adr,
                             input logic [`CSR_XLEN-1:0] wdata,
                             output logic [`CSR_XLEN-1:0] rdata, output logic err);
      int waited;
      waited = 0;
      @(posedge clk_in);
      priv_mode <= mode;
      wb_cyc    <= 1'b1;
      wb_stb    <= 1'b1;
      wb_we     <= we;
      wb_adr    <= adr;
      wb_dat_w  <= wdata;
      do
      begin
         @(posedge clk_in);
         waited++;
      end
      while (!wb_ack && !wb_err && waited < RESP_TIMEOUT);
      assert (wb_ack || wb_err)
      else stop_with_error($sformatf("no ack or err within %0d clocks for CSR %h",
                                     RESP_TIMEOUT, adr));
      rdata = wb_dat_r;
      err   = wb_err;
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
   endtask

   task automatic access_ok(input csr_pkg::priv_mode_e mode, input logic we,
                            input logic [`CSR_ADDR_W-1:0] adr,
                            input logic [`CSR_XLEN-1:0] wdata,
                            output logic [`CSR_XLEN-1:0] rdata);
      logic err;
      bus_access(mode, we, adr, wdata, rdata, err);
      assert (!err)
      else stop_with_error($sformatf("FAIL wb_err CSR %h: got %h, expected %h",
                                     adr, err, 1'b0));
   endtask

   // single-cycle retire pulses with the bus idle
   task automatic pulse_retire(input int unsigned n);
      for (int unsigned k = 0; k < n; k++)
      begin
         @(posedge clk_in);
         retire <= 1'b1;
         @(posedge clk_in);
         retire <= 1'b0;
      end
   endtask

   // ----------------------------------------
   // stimulus table
   task automatic build_table;
      // trap registers
      add_read(csr_pkg::PRIV_M, `CSR_MTVEC, `MTVEC_RESET);
      add_write(csr_pkg::PRIV_M, `CSR_MSCRATCH, rnd[0]);
      add_read(csr_pkg::PRIV_M, `CSR_MSCRATCH, rnd[0]);
      add_write(csr_pkg::PRIV_M, `CSR_MEPC, rnd[1]);
      add_read(csr_pkg::PRIV_M, `CSR_MEPC, rnd[1]);
      add_write(csr_pkg::PRIV_M, `CSR_MCAUSE, rnd[2]);
      add_read(csr_pkg::PRIV_M, `CSR_MCAUSE, rnd[2]);
      add_write(csr_pkg::PRIV_M, `CSR_MTVAL, rnd[3]);
      add_read(csr_pkg::PRIV_M, `CSR_MTVAL, rnd[3]);
      add_write(csr_pkg::PRIV_M, `CSR_MIE, rnd[4]);
      add_read(csr_pkg::PRIV_M, `CSR_MIE, rnd[4] & `MIE_MASK);
      // mtvec bit 1 written as one, reads as zero
      add_write(csr_pkg::PRIV_M, `CSR_MTVEC, rnd[5] | 32'h2);
      add_read(csr_pkg::PRIV_M, `CSR_MTVEC, rnd[5] & ~32'h2);
      // fixed and ID registers
      add_fixed(`CSR_MISA, `MISA_VAL);
      add_fixed(`CSR_MSTATUS, `MSTATUS_VAL);
      add_fixed(`CSR_MVENDORID, `MVENDORID_VAL);
      add_fixed(`CSR_MARCHID, `MARCHID_VAL);
      add_fixed(`CSR_MIMPID, `MIMPID_VAL);
      add_fixed(`CSR_MHARTID, `MHARTID_VAL);
      // satp, pmpcfg0, sstatus and dcsr are not implemented
      add_error(csr_pkg::PRIV_M, 1'b0, 12'h180, '0);
      add_error(csr_pkg::PRIV_M, 1'b1, 12'h180, rnd[0]);
      add_error(csr_pkg::PRIV_M, 1'b0, 12'h3A0, '0);
      add_error(csr_pkg::PRIV_M, 1'b1, 12'h3A0, rnd[1]);
      add_error(csr_pkg::PRIV_M, 1'b0, 12'h100, '0);
      add_error(csr_pkg::PRIV_M, 1'b0, 12'h7B0, '0);
      // user mode cannot reach machine CSRs
      add_error(csr_pkg::PRIV_U, 1'b0, `CSR_MSCRATCH, '0);
      add_error(csr_pkg::PRIV_U, 1'b1, `CSR_MEPC, rnd[2]);
      add_error(csr_pkg::PRIV_U, 1'b0, `CSR_MSTATUS, '0);
      add_error(csr_pkg::PRIV_U, 1'b0, `CSR_MCYCLE, '0);
      add_error(csr_pkg::PRIV_U, 1'b0, `CSR_MHARTID, '0);
      // freeze both counters, then load them
      add_write(csr_pkg::PRIV_M, `CSR_MCOUNTINHIBIT, 32'h5);
      add_read(csr_pkg::PRIV_M, `CSR_MCOUNTINHIBIT, 32'h5);
      add_write(csr_pkg::PRIV_M, `CSR_MCYCLE, rnd[6]);
      add_write(csr_pkg::PRIV_M, `CSR_MCYCLEH, rnd[7]);
      add_write(csr_pkg::PRIV_M, `CSR_MINSTRET, rnd[8]);
      add_write(csr_pkg::PRIV_M, `CSR_MINSTRETH, rnd[9]);
      add_read(csr_pkg::PRIV_M, `CSR_MCYCLE, rnd[6]);
      add_read(csr_pkg::PRIV_M, `CSR_MCYCLEH, rnd[7]);
      add_read(csr_pkg::PRIV_M, `CSR_MINSTRET, rnd[8]);
      add_read(csr_pkg::PRIV_M, `CSR_MINSTRETH, rnd[9]);
      // only time enabled for user mode
      add_write(csr_pkg::PRIV_M, `CSR_MCOUNTEREN, 32'h2);
      add_read(csr_pkg::PRIV_M, `CSR_MCOUNTEREN, 32'h2);
      add_read(csr_pkg::PRIV_U, `CSR_TIME, mtime_val[31:0]);
      add_read(csr_pkg::PRIV_U, `CSR_TIMEH, mtime_val[63:32]);
      add_error(csr_pkg::PRIV_U, 1'b0, `CSR_CYCLE, '0);
      add_error(csr_pkg::PRIV_U, 1'b0, `CSR_CYCLEH, '0);
      add_error(csr_pkg::PRIV_U, 1'b0, `CSR_INSTRET, '0);
      add_error(csr_pkg::PRIV_U, 1'b0, `CSR_INSTRETH, '0);
      // machine mode ignores mcounteren
      add_read(csr_pkg::PRIV_M, `CSR_CYCLE, rnd[6]);
      add_read(csr_pkg::PRIV_M, `CSR_INSTRETH, rnd[9]);
      add_write(csr_pkg::PRIV_M, `CSR_MCOUNTEREN, 32'h7);
      add_read(csr_pkg::PRIV_U, `CSR_CYCLE, rnd[6]);
      add_read(csr_pkg::PRIV_U, `CSR_CYCLEH, rnd[7]);
      add_read(csr_pkg::PRIV_U, `CSR_INSTRET, rnd[8]);
      add_read(csr_pkg::PRIV_U, `CSR_INSTRETH, rnd[9]);
      // shadows are read-only
      add_error(csr_pkg::PRIV_U, 1'b1, `CSR_CYCLE, rnd[0]);
      add_error(csr_pkg::PRIV_M, 1'b1, `CSR_TIME, rnd[1]);
   endtask

   // ----------------------------------------
   // clock and watchdog
   initial
   begin
      clk_in = 1'b0;
      forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
   end

   initial
   begin
      wait (watchdog_ns != 0);
      #(watchdog_ns);
      stop_with_error("watchdog expired before the tests finished");
   end

   // ----------------------------------------
   // main sequence
   initial
   begin
      logic [`CSR_XLEN-1:0] got_data;
      logic                 got_err;
      logic [`CSR_XLEN-1:0] first;
      logic [`CSR_XLEN-1:0] second;
      logic [`CSR_XLEN-1:0] cyc_base;
      int unsigned          n_retire;

      arst_n    = 1'b0;
      wb_cyc    = 1'b0;
      wb_stb    = 1'b0;
      wb_we     = 1'b0;
      wb_adr    = '0;
      wb_dat_w  = '0;
      priv_mode = csr_pkg::PRIV_M;
      retire    = 1'b0;
      mtime     = '0;

      void'($urandom(32'hed2f));
      for (int k = 0; k < 12; k++)
         rnd[k] = $urandom;
      mtime_val = {$urandom, $urandom};
      n_retire  = 1 + ($urandom % MAX_RETIRE);

      build_table();
      watchdog_ns = longint'(tbl_adr.size() + DIRECTED_OPS) * ACCESS_BUDGET * CLK_PERIOD
                    + longint'(RESET_CYCLES + 4 * MAX_RETIRE + 10) * CLK_PERIOD;

      repeat (RESET_CYCLES) @(posedge clk_in);
      arst_n <= 1'b1;
      mtime  <= mtime_val;

      for (int i = 0; i < tbl_adr.size(); i++)
      begin
         bus_access(tbl_mode[i], tbl_we[i], tbl_adr[i], tbl_wdata[i], got_data, got_err);
         assert (got_err == tbl_err[i])
         else stop_with_error($sformatf("FAIL wb_err entry %0d CSR %h: got %h, expected %h",
                                        i, tbl_adr[i], got_err, tbl_err[i]));
         // read data only matters for a legal read
         if (!tbl_we[i] && !tbl_err[i])
            assert (got_data == tbl_exp[i])
            else stop_with_error($sformatf("FAIL wb_dat_r entry %0d CSR %h: got %h, expected %h",
                                           i, tbl_adr[i], got_data, tbl_exp[i]));
      end

      // inhibit bit 2 still set, retire pulses leave minstret alone
      pulse_retire(n_retire);
      access_ok(csr_pkg::PRIV_M, 1'b0, `CSR_MINSTRET, '0, got_data);
      assert (got_data == rnd[8])
      else stop_with_error($sformatf("FAIL wb_dat_r minstret inhibited: got %h, expected %h",
                                     got_data, rnd[8]));

      // minstret counts retire pulses once inhibit bit 2 is clear
      access_ok(csr_pkg::PRIV_M, 1'b1, `CSR_MCOUNTINHIBIT, 32'h1, got_data);
      access_ok(csr_pkg::PRIV_M, 1'b1, `CSR_MINSTRET, rnd[10], got_data);
      pulse_retire(n_retire);
      access_ok(csr_pkg::PRIV_M, 1'b0, `CSR_MINSTRET, '0, got_data);
      assert (got_data == rnd[10] + n_retire)
      else stop_with_error($sformatf("FAIL wb_dat_r minstret after %0d retires: got %h, expected %h",
                                     n_retire, got_data, rnd[10] + n_retire));

      // mcycle runs freely once bit 0 is clear, start low to avoid a wrap
      cyc_base = rnd[11] & 32'h0fff_ffff;
      access_ok(csr_pkg::PRIV_M, 1'b1, `CSR_MCYCLE, cyc_base, got_data);
      access_ok(csr_pkg::PRIV_M, 1'b1, `CSR_MCOUNTINHIBIT, 32'h0, got_data);
      access_ok(csr_pkg::PRIV_M, 1'b0, `CSR_MCYCLE, '0, first);
      access_ok(csr_pkg::PRIV_M, 1'b0, `CSR_MCYCLE, '0, second);
      assert (second > first)
      else stop_with_error($sformatf("FAIL wb_dat_r mcycle not increasing: first %h, second %h",
                                     first, second));

      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

/* src.f */
+incdir+verilog
verilog/csr_pkg.sv
verilog/csr_decode.sv
verilog/csr_trap_regs.sv
verilog/csr_counters.sv
verilog/csr_wb_response.sv
verilog/csr_unit.sv
test/csr_unit_assertions.sv
test/csr_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the CSR block testbench with Verilator and run it
# exit status is the simulator's, non-zero on any failure
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f src.f --top-module csr_unit_tb \
   --Mdir obj_dir -o csr_unit_sim

./obj_dir/csr_unit_sim
